//--- src/rhd_acq_config.svh
`ifndef RHD_ACQ_CONFIG_SVH
`define RHD_ACQ_CONFIG_SVH

// Amplifier port
// Channels per MISO line
`define RHD_NUM_CH      32
`define RHD_SAMPLE_W    16
// SCLK half period is divider plus one bus_clk cycles
`define RHD_DIV_W       8
`define RHD_CMD_CONVERT 2'b00
// Amplifier answers a command two frames later
`define RHD_PIPE_LAG    2

// Output FIFO toward the host
`define MUA_FIFO_DEPTH  512

// Host register port
`define HOST_REG_W      16
`define HOST_ADDR_W     5

`endif

//--- src/rhd_pkg.sv
`default_nettype none

`include "rhd_acq_config.svh"

package rhd_pkg;

  // Raw word shifted in from one MISO line
  typedef logic [`RHD_SAMPLE_W-1:0] sample_t;

  typedef logic [$clog2(`RHD_NUM_CH)-1:0] chan_t;

  // 0 for MISO1, 1 for MISO2
  typedef logic [0:0] stream_t;

  // First difference of two unsigned samples needs one extra bit
  typedef logic signed [`RHD_SAMPLE_W:0] mua_t;

  typedef struct packed {
    logic    valid;
    stream_t stream;
    chan_t   chan;
    sample_t data;
  } rhd_sample_s;

  typedef struct packed {
    logic    valid;
    stream_t stream;
    chan_t   chan;
    mua_t    mua;
  } mua_sample_s;

endpackage

`default_nettype wire

//--- src/host_pkg.sv
`default_nettype none

`include "rhd_acq_config.svh"

package host_pkg;

  // Register map
  typedef enum logic [`HOST_ADDR_W-1:0] {
    REG_CTRL    = 0,
    REG_CLK_DIV = 1,
    REG_NUM_CH  = 2,
    REG_STATUS  = 3
  } reg_addr_e;

  typedef logic [`HOST_REG_W-1:0] reg_word_t;

  // MUA read stream word
  // [29] stream, [28:24] channel, [16:0] signed MUA, rest zero
  typedef logic [31:0] host_word_t;

  typedef struct packed {
    logic      wren;
    reg_addr_e addr;
    reg_word_t data;
  } reg_wr_s;

endpackage

`default_nettype wire

//--- src/rhd_spi_master.sv
`timescale 1ns/1ps
`default_nettype none

`include "rhd_acq_config.svh"

module rhd_spi_master (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  run,
  input  logic [`RHD_DIV_W-1:0] clk_div,
  input  rhd_pkg::chan_t        num_ch,
  input  logic                  miso1,
  input  logic                  miso2,
  output logic                  sclk,
  output logic                  cs,
  output logic                  mosi,
  output logic                  running,
  output rhd_pkg::rhd_sample_s  sample
);

  typedef enum logic [2:0] {IDLE, SHIFT, GAP, EMIT_A, EMIT_B} state_e;

  localparam int BITS      = `RHD_SAMPLE_W;
  localparam int BIT_CNT_W = $clog2(BITS);
  localparam int LAG       = `RHD_PIPE_LAG;
  localparam int FCNT_W    = $clog2(LAG + 1);

  state_e                state;
  logic [`RHD_DIV_W-1:0] div_cnt;
  logic [BIT_CNT_W-1:0]  bit_cnt;
  rhd_pkg::sample_t      cmd_sh;
  rhd_pkg::sample_t      cmd_word;
  rhd_pkg::sample_t      miso1_sh;
  rhd_pkg::sample_t      miso2_sh;
  rhd_pkg::chan_t        chan_cnt;
  rhd_pkg::chan_t        chan_hist [LAG];
  logic [FCNT_W-1:0]     frames_done;
  logic                  half_done;
  logic                  last_edge;
  logic                  gap_done;
  logic                  frame_start;

  assign half_done   = (div_cnt >= clk_div);
  // SCLK falling edge that closes bit 0 also raises CS
  assign last_edge   = (state == SHIFT) && half_done && sclk &&
                       (bit_cnt == BIT_CNT_W'(BITS - 1));
  // CS has been high for a full SCLK period
  assign gap_done    = (state == GAP) && half_done && bit_cnt[0];
  assign frame_start = run && ((state == IDLE) || gap_done);

  // Convert command, 6-bit channel field, don't-care tail
  assign cmd_word = {`RHD_CMD_CONVERT, 6'(chan_cnt), 8'h00};
  assign mosi     = cmd_sh[BITS-1];
  assign running  = (state != IDLE);

  // Half period counter that runs while a frame is active
  always_ff @(posedge clk) begin
    if (!rst_n || state == IDLE) begin
      div_cnt <= '0;
    end else if (half_done) begin
      div_cnt <= '0;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state        <= IDLE;
      cs           <= 1'b1;
      sclk         <= 1'b0;
      bit_cnt      <= '0;
      cmd_sh       <= '0;
      sample.valid <= 1'b0;
    end else begin
      case (state)
        SHIFT: begin
          if (half_done) begin
            sclk <= ~sclk;
            if (!sclk) begin
              // End of low half, capture both lines
              miso1_sh <= {miso1_sh[BITS-2:0], miso1};
              miso2_sh <= {miso2_sh[BITS-2:0], miso2};
            end else begin
              cmd_sh <= {cmd_sh[BITS-2:0], 1'b0};
              if (last_edge) begin
                cs            <= 1'b1;
                state         <= EMIT_A;
                bit_cnt       <= '0;
                sample.valid  <= (frames_done == FCNT_W'(LAG));
                sample.stream <= 1'b0;
                sample.chan   <= chan_hist[LAG-1];
                sample.data   <= miso1_sh;
              end else begin
                bit_cnt <= bit_cnt + 1'b1;
              end
            end
          end
        end
        EMIT_A: begin
          state         <= EMIT_B;
          sample.stream <= 1'b1;
          sample.data   <= miso2_sh;
        end
        EMIT_B: begin
          state        <= GAP;
          sample.valid <= 1'b0;
          if (half_done) begin
            bit_cnt <= BIT_CNT_W'(1);
          end
        end
        GAP: begin
          if (half_done) begin
            if (bit_cnt[0]) begin
              state <= IDLE;
            end else begin
              bit_cnt <= BIT_CNT_W'(1);
            end
          end
        end
        default: state <= IDLE;
      endcase

      // Overrides the GAP exit when run is still set
      if (frame_start) begin
        state   <= SHIFT;
        cs      <= 1'b0;
        bit_cnt <= '0;
        cmd_sh  <= cmd_word;
      end
    end
  end

  // Channel sequencing that restarts at 0 whenever acquisition stops
  always_ff @(posedge clk) begin
    if (!rst_n || (gap_done && !run)) begin
      chan_cnt    <= '0;
      frames_done <= '0;
    end else if (last_edge) begin
      chan_cnt <= (chan_cnt >= num_ch) ? '0 : chan_cnt + 1'b1;
      if (frames_done != FCNT_W'(LAG)) begin
        frames_done <= frames_done + 1'b1;
      end
    end
  end

  // Channels commanded in the last LAG frames
  always_ff @(posedge clk) begin
    if (last_edge) begin
      chan_hist[0] <= chan_cnt;
      for (int i = 1; i < LAG; i++) begin
        chan_hist[i] <= chan_hist[i-1];
      end
    end
  end

endmodule

`default_nettype wire

//--- src/ctrl_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "rhd_acq_config.svh"

module ctrl_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  input  host_pkg::reg_wr_s     wr,
  input  logic                  rden,
  input  host_pkg::reg_addr_e   addr,
  input  logic                  running,
  input  logic                  overflow,
  output logic                  run,
  output logic [`RHD_DIV_W-1:0] clk_div,
  output rhd_pkg::chan_t        num_ch,
  output host_pkg::reg_word_t   rd_data
);

  localparam host_pkg::reg_word_t DIV_MAX = host_pkg::reg_word_t'((1 << `RHD_DIV_W) - 1);
  localparam host_pkg::reg_word_t CH_MAX  = host_pkg::reg_word_t'(`RHD_NUM_CH);

  host_pkg::reg_word_t div_sat;
  host_pkg::reg_word_t ch_sat;
  host_pkg::reg_word_t rd_next;

  // Divider 1..255, channel count 1..32
  assign div_sat = (wr.data == '0) ? host_pkg::reg_word_t'(1) :
                   (wr.data > DIV_MAX) ? DIV_MAX : wr.data;
  assign ch_sat  = (wr.data == '0) ? host_pkg::reg_word_t'(1) :
                   (wr.data > CH_MAX) ? CH_MAX : wr.data;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run     <= 1'b0;
      clk_div <= `RHD_DIV_W'(1);
      num_ch  <= rhd_pkg::chan_t'(`RHD_NUM_CH - 1);
    end else if (wr.wren) begin
      case (wr.addr)
        host_pkg::REG_CTRL:    run     <= wr.data[0];
        host_pkg::REG_CLK_DIV: clk_div <= div_sat[`RHD_DIV_W-1:0];
        // Stored as count minus one
        host_pkg::REG_NUM_CH:  num_ch  <= rhd_pkg::chan_t'(ch_sat - 1'b1);
        default: ;
      endcase
    end
  end

  always_comb begin
    case (addr)
      host_pkg::REG_CTRL:    rd_next = host_pkg::reg_word_t'(run);
      host_pkg::REG_CLK_DIV: rd_next = host_pkg::reg_word_t'(clk_div);
      host_pkg::REG_NUM_CH:  rd_next = host_pkg::reg_word_t'(num_ch) + 1'b1;
      host_pkg::REG_STATUS:  rd_next = host_pkg::reg_word_t'({overflow, running});
      default:               rd_next = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rden) begin
      rd_data <= rd_next;
    end
  end

endmodule

`default_nettype wire

//--- src/mua_highpass.sv
`timescale 1ns/1ps
`default_nettype none

module mua_highpass (
  input  logic                 clk,
  input  logic                 rst_n,
  input  rhd_pkg::rhd_sample_s in_sample,
  output rhd_pkg::mua_sample_s out_sample
);

  // One history slot per stream and channel
  localparam int IDX_W = $bits(rhd_pkg::stream_t) + $bits(rhd_pkg::chan_t);
  localparam int DEPTH = 1 << IDX_W;

  rhd_pkg::sample_t hist_mem [DEPTH];
  logic [DEPTH-1:0] written;
  logic [IDX_W-1:0] idx;
  rhd_pkg::sample_t prev;
  rhd_pkg::mua_t    diff;

  assign idx  = {in_sample.stream, in_sample.chan};
  // Slots never written read as zero
  assign prev = written[idx] ? hist_mem[idx] : '0;

  // Both operands zero-extended, result wraps into signed 17 bits
  assign diff = rhd_pkg::mua_t'({1'b0, in_sample.data}) -
                rhd_pkg::mua_t'({1'b0, prev});

  always_ff @(posedge clk) begin
    if (in_sample.valid) begin
      hist_mem[idx] <= in_sample.data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      written <= '0;
    end else if (in_sample.valid) begin
      written[idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_sample.valid <= 1'b0;
    end else begin
      out_sample.valid <= in_sample.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_sample.valid) begin
      out_sample.stream <= in_sample.stream;
      out_sample.chan   <= in_sample.chan;
      out_sample.mua    <= diff;
    end
  end

endmodule

`default_nettype wire

//--- src/mua_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "rhd_acq_config.svh"

module mua_fifo #(
  parameter int DEPTH = `MUA_FIFO_DEPTH
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 open,
  input  rhd_pkg::mua_sample_s wr,
  input  logic                 rden,
  output host_pkg::host_word_t data,
  output logic                 empty,
  output logic                 overflow
);

  localparam int AW = $clog2(DEPTH);

  host_pkg::host_word_t mem [DEPTH];
  host_pkg::host_word_t wr_word;
  logic [AW-1:0]        wr_ptr;
  logic [AW-1:0]        rd_ptr;
  logic [AW:0]          count;
  logic                 full;
  logic                 do_wr;
  logic                 do_rd;

  // Host word layout
  assign wr_word = {2'b00, wr.stream, wr.chan, 7'b0, wr.mua};

  assign full  = (count == (AW + 1)'(DEPTH));
  assign empty = (count == '0);
  assign do_wr = open && wr.valid && !full;
  assign do_rd = rden && !empty;

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_word;
    end
    if (do_rd) begin
      data <= mem[rd_ptr];
    end
  end

  // Closed port flushes the buffer and clears the sticky flag
  always_ff @(posedge clk) begin
    if (!rst_n || !open) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      overflow <= 1'b0;
    end else begin
      if (do_wr) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
      // Word lost, nothing upstream waits
      if (wr.valid && full) begin
        overflow <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- src/rhd_acq_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "rhd_acq_config.svh"

module rhd_acq_top (
  input  logic                 bus_clk,
  input  logic                 rst_n,
  input  host_pkg::reg_wr_s    reg_wr,
  input  logic                 reg_rden,
  input  host_pkg::reg_addr_e  reg_rd_addr,
  output host_pkg::reg_word_t  reg_rd_data,
  input  logic                 miso1,
  input  logic                 miso2,
  output logic                 sclk,
  output logic                 cs,
  output logic                 mosi,
  input  logic                 mua_rden,
  input  logic                 mua_open,
  output host_pkg::host_word_t mua_data,
  output logic                 mua_empty
);

  logic                  run;
  logic                  running;
  logic                  overflow;
  logic [`RHD_DIV_W-1:0] clk_div;
  rhd_pkg::chan_t        num_ch;
  rhd_pkg::rhd_sample_s  raw_sample;
  rhd_pkg::mua_sample_s  mua_sample;

  ctrl_regs regs (
    .clk     (bus_clk    ),
    .rst_n   (rst_n      ),
    .wr      (reg_wr     ),
    .rden    (reg_rden   ),
    .addr    (reg_rd_addr),
    .running (running    ),
    .overflow(overflow   ),
    .run     (run        ),
    .clk_div (clk_div    ),
    .num_ch  (num_ch     ),
    .rd_data (reg_rd_data)
  );

  rhd_spi_master intan_spi (
    .clk    (bus_clk   ),
    .rst_n  (rst_n     ),
    .run    (run       ),
    .clk_div(clk_div   ),
    .num_ch (num_ch    ),
    .miso1  (miso1     ),
    .miso2  (miso2     ),
    .sclk   (sclk      ),
    .cs     (cs        ),
    .mosi   (mosi      ),
    .running(running   ),
    .sample (raw_sample)
  );

  mua_highpass mua_filter (
    .clk       (bus_clk   ),
    .rst_n     (rst_n     ),
    .in_sample (raw_sample),
    .out_sample(mua_sample)
  );

  mua_fifo #(
    .DEPTH(`MUA_FIFO_DEPTH)
  ) fifo_to_host (
    .clk     (bus_clk   ),
    .rst_n   (rst_n     ),
    .open    (mua_open  ),
    .wr      (mua_sample),
    .rden    (mua_rden  ),
    .data    (mua_data  ),
    .empty   (mua_empty ),
    .overflow(overflow  )
  );

endmodule

`default_nettype wire

//--- test/rhd_acq_assert.sv
`timescale 1ns/1ps
`default_nettype none

module rhd_acq_assert (
  input logic clk,
  input logic rst_n,
  input logic cs,
  input logic sclk,
  input logic run,
  input logic running,
  input logic mua_open,
  input logic mua_rden,
  input logic mua_empty,
  input logic overflow
);

  // SCLK idles low between frames
  sclk_low_outside_frame: assert property (@(posedge clk) disable iff (!rst_n)
    cs |-> !sclk)
    else $error("SCLK high while CS is high");

  // A frame only starts with run set
  frame_needs_run: assert property (@(posedge clk) disable iff (!rst_n)
    $fell(cs) |-> $past(run))
    else $error("CS fell without run");

  idle_keeps_cs_high: assert property (@(posedge clk) disable iff (!rst_n)
    !running |-> cs)
    else $error("CS low while the SPI master is idle");

  // Host side read rule
  read_only_when_filled: assert property (@(posedge clk) disable iff (!rst_n)
    mua_rden |-> !mua_empty)
    else $error("FIFO read while empty");

  closed_fifo_is_flushed: assert property (@(posedge clk) disable iff (!rst_n)
    !mua_open |=> (mua_empty && !overflow))
    else $error("FIFO not flushed while closed");

endmodule

`default_nettype wire

//--- test/tb_rhd_acq.sv
`timescale 1ns/1ps
`default_nettype none

`include "rhd_acq_config.svh"

module tb_rhd_acq;

  // Divider 1 gives 2-cycle half periods with 32 halves and a 2-half gap
  localparam int HALF_CYC    = 2;
  localparam int FRAME_CYC   = 2 * `RHD_SAMPLE_W * HALF_CYC + 2 * HALF_CYC;
  localparam int MAX_FRAMES  = 340;
  localparam int TIMEOUT_CYC = FRAME_CYC * MAX_FRAMES + 8000;

  typedef struct packed {
    host_pkg::reg_addr_e addr;
    host_pkg::reg_word_t wdata;
    host_pkg::reg_word_t rexp;
  } reg_step_s;

  logic                 bus_clk;
  logic                 rst_n;
  host_pkg::reg_wr_s    reg_wr;
  logic                 reg_rden;
  host_pkg::reg_addr_e  reg_rd_addr;
  host_pkg::reg_word_t  reg_rd_data;
  logic                 miso1 = 1'b0;
  logic                 miso2 = 1'b0;
  logic                 sclk;
  logic                 cs;
  logic                 mosi;
  logic                 mua_rden;
  logic                 mua_open;
  host_pkg::host_word_t mua_data;
  logic                 mua_empty;

  reg_step_s            reg_table [9];
  host_pkg::host_word_t exp_q [$];
  logic [15:0]          ref_hist [2][32];
  int                   cur_div;
  int                   cur_nch;
  int                   amp_frame;
  int                   cycles = 0;
  logic                 stopped_check;
  logic                 prev_cs;
  logic                 prev_sclk;
  logic [15:0]          mosi_sh;
  logic [15:0]          amp_sh1;
  logic [15:0]          amp_sh2;
  int                   level_len;
  int                   rises;
  int                   hi_len;
  logic                 mon_cs;
  logic                 mon_sclk;

  rhd_acq_top uut (
    .bus_clk    (bus_clk    ),
    .rst_n      (rst_n      ),
    .reg_wr     (reg_wr     ),
    .reg_rden   (reg_rden   ),
    .reg_rd_addr(reg_rd_addr),
    .reg_rd_data(reg_rd_data),
    .miso1      (miso1      ),
    .miso2      (miso2      ),
    .sclk       (sclk       ),
    .cs         (cs         ),
    .mosi       (mosi       ),
    .mua_rden   (mua_rden   ),
    .mua_open   (mua_open   ),
    .mua_data   (mua_data   ),
    .mua_empty  (mua_empty  )
  );

  bind rhd_acq_top rhd_acq_assert checks (
    .clk(bus_clk), .rst_n(rst_n), .cs(cs), .sclk(sclk), .run(run),
    .running(running), .mua_open(mua_open), .mua_rden(mua_rden),
    .mua_empty(mua_empty), .overflow(overflow)
  );

  initial bus_clk = 1'b0;
  always #10 bus_clk = ~bus_clk;

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("Regression failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp,
                             input logic [31:0] act);
    assert (exp === act) else begin
      stop_on_error($sformatf("ERROR %0t %s expected %h got %h", $time, name, exp, act));
    end
  endtask

  // Reference first difference per stream and channel
  function automatic void push_expected(input logic s, input logic [4:0] c,
                                        input logic [15:0] d);
    logic [16:0] diff;
    diff = 17'({1'b0, d}) - 17'({1'b0, ref_hist[s][c]});
    exp_q.push_back({2'b00, s, c, 7'b0, diff});
    ref_hist[s][c] = d;
  endfunction

  task automatic write_reg(input host_pkg::reg_addr_e a, input host_pkg::reg_word_t d);
    @(posedge bus_clk);
    reg_wr <= '{wren: 1'b1, addr: a, data: d};
    @(posedge bus_clk);
    reg_wr.wren <= 1'b0;
  endtask

  task automatic read_reg(input host_pkg::reg_addr_e a, output host_pkg::reg_word_t d);
    @(posedge bus_clk);
    reg_rden    <= 1'b1;
    reg_rd_addr <= a;
    @(posedge bus_clk);
    reg_rden <= 1'b0;
    @(negedge bus_clk);
    d = reg_rd_data;
  endtask

  task automatic pop_check();
    host_pkg::host_word_t w;
    @(negedge bus_clk);
    while (mua_empty) @(negedge bus_clk);
    @(posedge bus_clk);
    mua_rden <= 1'b1;
    @(posedge bus_clk);
    mua_rden <= 1'b0;
    @(negedge bus_clk);
    w = mua_data;
    assert (exp_q.size() > 0) else begin
      stop_on_error("FIFO returned a word that no amplifier sample accounts for");
    end
    check_value("mua_data", exp_q.pop_front(), w);
  endtask

  task automatic start_run();
    host_pkg::reg_word_t d;
    write_reg(host_pkg::REG_CTRL, 16'h0001);
    read_reg(host_pkg::REG_STATUS, d);
    check_value("REG_STATUS.running", 32'(1), 32'(d[0]));
  endtask

  // Current frame finishes before running drops
  task automatic stop_run();
    host_pkg::reg_word_t d;
    write_reg(host_pkg::REG_CTRL, 16'h0000);
    d = 16'h0001;
    while (d[0]) read_reg(host_pkg::REG_STATUS, d);
  endtask

  task automatic drain();
    while (exp_q.size() > 0) pop_check();
    @(negedge bus_clk);
    check_value("mua_empty", 32'(1), 32'(mua_empty));
  endtask

  // Amplifier model that answers each command two frames late
  always @(posedge bus_clk) begin
    logic [4:0]  lag_ch;
    logic [15:0] w1;
    logic [15:0] w2;
    if (!rst_n) begin
      prev_cs   = 1'b1;
      prev_sclk = 1'b0;
      amp_frame = 0;
      foreach (ref_hist[s, c]) ref_hist[s][c] = '0;
    end else begin
      if (reg_wr.wren && reg_wr.addr == host_pkg::REG_CTRL && reg_wr.data[0]) begin
        amp_frame = 0;
      end
      w1 = 16'($urandom);
      w2 = 16'($urandom);
      if (prev_cs && !cs) begin
        if (amp_frame >= `RHD_PIPE_LAG) begin
          lag_ch = 5'((amp_frame - `RHD_PIPE_LAG) % cur_nch);
          push_expected(1'b0, lag_ch, w1);
          push_expected(1'b1, lag_ch, w2);
        end
        miso1   <= w1[15];
        miso2   <= w2[15];
        amp_sh1 = w1 << 1;
        amp_sh2 = w2 << 1;
      end else if (!cs && prev_sclk && !sclk) begin
        miso1   <= amp_sh1[15];
        miso2   <= amp_sh2[15];
        amp_sh1 = amp_sh1 << 1;
        amp_sh2 = amp_sh2 << 1;
      end
      if (!cs && !prev_sclk && sclk) begin
        mosi_sh = {mosi_sh[14:0], mosi};
      end
      if (!prev_cs && cs) begin
        check_value("mosi_word",
                    32'({`RHD_CMD_CONVERT, 6'(amp_frame % cur_nch), 8'h00}),
                    32'(mosi_sh));
        amp_frame++;
      end
      prev_cs   = cs;
      prev_sclk = sclk;
    end
  end

  // Frame shape checks on half periods, SCLK count and the CS gap
  always @(posedge bus_clk) begin
    if (!rst_n) begin
      mon_cs    = 1'b1;
      mon_sclk  = 1'b0;
      level_len = 0;
      rises     = 0;
      hi_len    = 0;
    end else begin
      if (cs) begin
        assert (!sclk) else stop_on_error("SCLK went high while CS was high");
        if (!mon_cs) begin
          check_value("sclk_rises", 32'(16), 32'(rises));
          check_value("sclk_half_len", 32'(cur_div + 1), 32'(level_len));
          hi_len = 0;
        end
        hi_len++;
      end else begin
        assert (!stopped_check) else stop_on_error("CS fell after acquisition was stopped");
        if (mon_cs) begin
          assert (hi_len >= 2 * (cur_div + 1)) else
            stop_on_error("CS gap between frames shorter than one SCLK period");
          level_len = 1;
          rises     = 0;
        end else if (sclk != mon_sclk) begin
          check_value("sclk_half_len", 32'(cur_div + 1), 32'(level_len));
          level_len = 1;
          if (sclk) rises++;
        end else begin
          level_len++;
        end
      end
      mon_cs   = cs;
      mon_sclk = sclk;
    end
  end

  always @(posedge bus_clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYC) begin
      stop_on_error($sformatf("Timeout after %0d cycles, the DUT stopped responding", cycles));
    end
  end

  initial begin
    host_pkg::reg_word_t d;
    void'($urandom(32'h525b));
    rst_n         = 1'b0;
    reg_wr        = '{wren: 1'b0, addr: host_pkg::REG_CTRL, data: '0};
    reg_rden      = 1'b0;
    reg_rd_addr   = host_pkg::REG_CTRL;
    mua_rden      = 1'b0;
    mua_open      = 1'b1;
    stopped_check = 1'b0;
    cur_div       = 1;
    cur_nch       = 32;
    // Address, written value, expected read-back
    reg_table = '{
      '{host_pkg::REG_CLK_DIV, 16'd300,    16'd255},
      '{host_pkg::REG_CLK_DIV, 16'd3,      16'd3},
      '{host_pkg::REG_CLK_DIV, 16'd0,      16'd1},
      '{host_pkg::REG_NUM_CH,  16'd40,     16'd32},
      '{host_pkg::REG_NUM_CH,  16'd0,      16'd1},
      '{host_pkg::REG_NUM_CH,  16'd7,      16'd7},
      '{host_pkg::REG_CTRL,    16'd0,      16'd0},
      '{host_pkg::REG_STATUS,  16'hffff,   16'd0},
      '{host_pkg::REG_CTRL,    16'h0002,   16'd0}
    };
    repeat (4) @(posedge bus_clk);
    rst_n <= 1'b1;

    foreach (reg_table[i]) begin
      write_reg(reg_table[i].addr, reg_table[i].wdata);
      read_reg(reg_table[i].addr, d);
      check_value($sformatf("reg_rd_data[%0d]", reg_table[i].addr), 32'(reg_table[i].rexp),
                  32'(d));
    end
    cur_div = 1;
    cur_nch = 7;

    // Live acquisition with the host reading
    start_run();
    repeat (40) pop_check();
    stop_run();
    drain();

    // Host idle until the FIFO overflows
    start_run();
    while (exp_q.size() < `MUA_FIFO_DEPTH + 8) @(posedge bus_clk);
    stop_run();
    read_reg(host_pkg::REG_STATUS, d);
    check_value("REG_STATUS.overflow", 32'(1), 32'(d[1]));
    repeat (`MUA_FIFO_DEPTH) pop_check();
    @(negedge bus_clk);
    check_value("mua_empty", 32'(1), 32'(mua_empty));
    exp_q.delete();

    // Closing the port flushes words and the overflow flag
    start_run();
    while (exp_q.size() < 6) @(posedge bus_clk);
    stop_run();
    @(negedge bus_clk);
    check_value("mua_empty", 32'(0), 32'(mua_empty));
    @(posedge bus_clk);
    mua_open <= 1'b0;
    @(posedge bus_clk);
    mua_open <= 1'b1;
    @(negedge bus_clk);
    check_value("mua_empty", 32'(1), 32'(mua_empty));
    read_reg(host_pkg::REG_STATUS, d);
    check_value("REG_STATUS.overflow", 32'(0), 32'(d[1]));
    exp_q.delete();

    // After stop, CS stays high and nothing new arrives
    start_run();
    repeat (10) pop_check();
    stop_run();
    drain();
    stopped_check = 1'b1;
    repeat (300) begin
      @(negedge bus_clk);
      check_value("mua_empty", 32'(1), 32'(mua_empty));
    end
    stopped_check = 1'b0;

    $display("Regression passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- rhd_acq.f
+incdir+src
src/rhd_pkg.sv
src/host_pkg.sv
src/rhd_spi_master.sv
src/ctrl_regs.sv
src/mua_highpass.sv
src/mua_fifo.sv
src/rhd_acq_top.sv
test/rhd_acq_assert.sv
test/tb_rhd_acq.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_rhd_acq
FILELIST  = rhd_acq.f
PASS_MSG  = Regression passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf obj_dir
